// ==== hw/video_settings.svh ====
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

`default_nettype none

// Visible frame, raster order
`define FRAME_W      64
`define FRAME_H      32
`define FRAME_XW     6
`define FRAME_YW     5

// Square tiles
`define TILE_PIX     8

// Character map covers the frame exactly
`define CHAR_MAP_W   8
`define CHAR_MAP_H   4

// Scroll plane is 128x64 and wraps both ways
`define SCR_MAP_W    16
`define SCR_MAP_H    8
`define SCR_XW       7
`define SCR_YW       6

// Pattern memory per layer, two 4-bit pixels per byte
`define TILE_COUNT   16
`define TILE_BYTES   32

// Palette, one entry per layer/pal/colour combination
`define PAL_ENTRIES  128
`define PAL_AW       7

`default_nettype wire

`endif

// ==== hw/video_pkg.sv ====
`default_nettype none

package video_pkg;

    // Colour code out of the pattern memory, 0 is see-through
    typedef logic [3:0] pixel_t;

    // Character tile attribute byte
    typedef struct packed {
        logic [1:0] pal;
        logic       hflip;
        logic [4:0] spare;
    } char_attr_t;

    // Scroll tile attribute byte
    typedef struct packed {
        logic [1:0] pal;
        logic       hflip;
        logic       prio;   // Opaque scroll pixels cover the character layer
        logic [3:0] spare;
    } scr_attr_t;

    // Palette address as built by the mixer
    typedef struct packed {
        logic       layer;  // 1 = character
        logic [1:0] pal;
        pixel_t     color;
    } pal_index_t;

endpackage

`default_nettype wire

// ==== hw/raster_scan.sv ====
`timescale 1ns/1ns
`include "video_settings.svh"
`default_nettype none

module raster_scan (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  render_en,
    input  logic                  advance,
    input  logic [`SCR_YW-1:0]    scr_vpos,
    input  logic [`SCR_XW-1:0]    scr_hpos,
    input  logic                  pos_done,
    output logic                  busy,
    output logic                  pos_valid,
    output logic [`FRAME_XW-1:0]  char_x,
    output logic [`FRAME_YW-1:0]  char_y,
    output logic [`SCR_XW-1:0]    scr_x,
    output logic [`SCR_YW-1:0]    scr_y,
    output logic [`FRAME_XW-1:0]  pos_x,
    output logic [`FRAME_YW-1:0]  pos_y,
    output logic                  pos_last
);

    logic [`SCR_XW-1:0] hoff;
    logic [`SCR_YW-1:0] voff;
    logic               start;
    logic               line_end;

    assign start    = render_en && !busy;
    assign line_end = (pos_x == (`FRAME_W - 1));
    assign pos_last = line_end && (pos_y == (`FRAME_H - 1));

    // Stage 0 position and frame control
    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            pos_valid <= 1'b0;
            pos_x     <= '0;
            pos_y     <= '0;
        end else if (start) begin
            busy      <= 1'b1;
            pos_valid <= 1'b1;
            pos_x     <= '0;
            pos_y     <= '0;
        end else begin
            // Busy holds until the final pixel leaves the output register
            if (pos_done)
                busy <= 1'b0;
            if (pos_valid && advance) begin
                if (pos_last)
                    pos_valid <= 1'b0;
                pos_x <= line_end ? '0 : pos_x + 1'b1;
                if (line_end)
                    pos_y <= pos_last ? '0 : pos_y + 1'b1;
            end
        end
    end

    // Offsets are frozen for the whole frame
    always_ff @(posedge clk) begin
        if (start) begin
            hoff <= scr_hpos;
            voff <= scr_vpos;
        end
    end

    assign char_x = pos_x;
    assign char_y = pos_y;

    // Natural width wrap gives the 128x64 plane
    assign scr_x = {1'b0, pos_x} + hoff;
    assign scr_y = {1'b0, pos_y} + voff;

    // Counter rests at the origin between frames
    assert property (@(posedge clk) disable iff (reset)
        !pos_valid |-> pos_x == '0 && pos_y == '0);

endmodule

`default_nettype wire

// ==== hw/tile_layer.sv ====
`timescale 1ns/1ns
`include "video_settings.svh"
`default_nettype none

module tile_layer import video_pkg::*; #(
    parameter type attr_t = char_attr_t,
    parameter int  MAP_W  = `CHAR_MAP_W,
    parameter int  MAP_H  = `CHAR_MAP_H,
    localparam int X_W    = $clog2(MAP_W * `TILE_PIX),
    localparam int Y_W    = $clog2(MAP_H * `TILE_PIX)
)(
    input  logic            clk,
    input  logic            reset,
    input  logic            advance,
    input  logic            cpu_we,
    input  logic            cpu_sel,
    input  logic [9:0]      cpu_addr,
    input  logic [7:0]      cpu_din,
    input  logic [X_W-1:0]  tx,
    input  logic [Y_W-1:0]  ty,
    input  logic            in_valid,
    output pixel_t          pxl,
    output attr_t           attr,
    output logic            out_valid
);

    localparam int MAP_N  = MAP_W * MAP_H;
    localparam int IDX_W  = $clog2(MAP_N);
    localparam int TP_W   = $clog2(`TILE_PIX);
    localparam int CODE_W = $clog2(`TILE_COUNT);
    localparam int PAT_N  = `TILE_COUNT * `TILE_BYTES;

    // Map split in code and attribute halves of each two-byte entry
    logic [CODE_W-1:0] map_code [MAP_N];
    attr_t             map_attr [MAP_N];
    logic [7:0]        pat_mem  [PAT_N];

    logic [IDX_W-1:0]  map_idx;

    logic              s1_valid;
    logic [CODE_W-1:0] s1_code;
    attr_t             s1_attr;
    logic [TP_W-1:0]   s1_row;
    logic [TP_W-1:0]   s1_col;

    logic [TP_W-1:0]   col_eff;
    logic [$clog2(PAT_N)-1:0] pat_addr;
    logic [7:0]        pat_byte;

    // CPU side
    always_ff @(posedge clk) begin
        if (cpu_we && cpu_sel) begin
            if (cpu_addr[9])
                pat_mem[cpu_addr[8:0]] <= cpu_din;
            else if (cpu_addr[0])
                map_attr[cpu_addr[IDX_W:1]] <= attr_t'(cpu_din);
            else
                map_code[cpu_addr[IDX_W:1]] <= cpu_din[CODE_W-1:0];
        end
    end

    // Tile row in the upper bits, tile column in the lower
    assign map_idx = {ty[Y_W-1:TP_W], tx[X_W-1:TP_W]};

    // Valid bits of stages 1 and 2
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    // Stage 1 map read
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_code <= map_code[map_idx];
            s1_attr <= map_attr[map_idx];
            s1_row  <= ty[TP_W-1:0];
            s1_col  <= tx[TP_W-1:0];
        end
    end

    // Mirrored column reads the tile right to left
    assign col_eff  = s1_attr.hflip ? ~s1_col : s1_col;

    // Four bytes per tile row
    assign pat_addr = {s1_code, s1_row, col_eff[TP_W-1:1]};
    assign pat_byte = pat_mem[pat_addr];

    // Stage 2 pattern read, lower nibble is the left pixel
    always_ff @(posedge clk) begin
        if (advance) begin
            pxl  <= col_eff[0] ? pat_byte[7:4] : pat_byte[3:0];
            attr <= s1_attr;
        end
    end

    // CPU owns the memories only while the raster is idle
    assert property (@(posedge clk) disable iff (reset)
        cpu_we && cpu_sel |-> !in_valid);

endmodule

`default_nettype wire

// ==== hw/color_mixer.sv ====
`timescale 1ns/1ns
`include "video_settings.svh"
`default_nettype none

module color_mixer import video_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  pixel_t                char_pxl,
    input  char_attr_t            char_attr,
    input  pixel_t                scr_pxl,
    input  scr_attr_t             scr_attr,
    input  logic [`FRAME_XW-1:0]  in_x,
    input  logic [`FRAME_YW-1:0]  in_y,
    input  logic                  in_last,
    input  logic                  cpu_we,
    input  logic                  pal_cs,
    input  logic [7:0]            cpu_addr,
    input  logic [7:0]            cpu_din,
    input  logic                  out_ready,
    output logic                  advance,
    output logic                  pos_done,
    output logic                  out_valid,
    output logic [`FRAME_XW-1:0]  out_x,
    output logic [`FRAME_YW-1:0]  out_y,
    output logic                  out_last,
    output logic [3:0]            red,
    output logic [3:0]            green,
    output logic [3:0]            blue
);

    // Red in the upper nibble, green in the lower
    logic [7:0]           pal_rg [`PAL_ENTRIES];
    logic [3:0]           pal_b  [`PAL_ENTRIES];

    logic                 sel_char;
    pal_index_t           pal_idx;

    logic                 s3_valid;
    logic [`FRAME_XW-1:0] s3_x;
    logic [`FRAME_YW-1:0] s3_y;
    logic                 s3_last;
    logic [7:0]           s3_rg;
    logic [3:0]           s3_b;

    // Palette writes
    always_ff @(posedge clk) begin
        if (cpu_we && pal_cs) begin
            if (cpu_addr[7])
                pal_b[cpu_addr[`PAL_AW-1:0]] <= cpu_din[3:0];
            else
                pal_rg[cpu_addr[`PAL_AW-1:0]] <= cpu_din;
        end
    end

    // Layer selection
    always_comb begin
        if (scr_attr.prio && scr_pxl != '0)
            sel_char = 1'b0;
        else if (char_pxl != '0)
            sel_char = 1'b1;
        else
            sel_char = 1'b0;

        pal_idx.layer = sel_char;
        pal_idx.pal   = sel_char ? char_attr.pal : scr_attr.pal;
        pal_idx.color = sel_char ? char_pxl : scr_pxl;
    end

    // Pipeline moves when the output slot is free or being taken
    assign advance  = !out_valid || out_ready;
    assign pos_done = out_valid && out_ready && out_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            s3_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s3_valid  <= in_valid;
            out_valid <= s3_valid;
        end
    end

    // Stage 3 palette lookup
    always_ff @(posedge clk) begin
        if (advance) begin
            s3_x    <= in_x;
            s3_y    <= in_y;
            s3_last <= in_last;
            s3_rg   <= pal_rg[pal_idx];
            s3_b    <= pal_b[pal_idx];
        end
    end

    // Stage 4 output register
    always_ff @(posedge clk) begin
        if (advance) begin
            out_x    <= s3_x;
            out_y    <= s3_y;
            out_last <= s3_last;
            red      <= s3_rg[7:4];
            green    <= s3_rg[3:0];
            blue     <= s3_b;
        end
    end

    // Stalled pixel is held until the sink takes it
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=>
            out_valid && $stable({out_x, out_y, out_last, red, green, blue}));

    // No palette update under a pixel that is about to read it
    assert property (@(posedge clk) disable iff (reset)
        cpu_we && pal_cs |-> !in_valid && !s3_valid);

endmodule

`default_nettype wire

// ==== hw/tile_video.sv ====
`timescale 1ns/1ns
`include "video_settings.svh"
`default_nettype none

module tile_video import video_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    // CPU bus
    input  logic                  cpu_we,
    input  logic [9:0]            cpu_addr,
    input  logic [7:0]            cpu_din,
    input  logic                  char_cs,
    input  logic                  scr_cs,
    input  logic                  pal_cs,
    // Frame control
    input  logic                  render_en,
    input  logic [`SCR_XW-1:0]    scr_hpos,
    input  logic [`SCR_YW-1:0]    scr_vpos,
    output logic                  busy,
    // Pixel stream
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [`FRAME_XW-1:0]  out_x,
    output logic [`FRAME_YW-1:0]  out_y,
    output logic                  out_last,
    output logic [3:0]            red,
    output logic [3:0]            green,
    output logic [3:0]            blue
);

    logic                 advance;
    logic                 pos_done;
    logic                 pos_valid;
    logic [`FRAME_XW-1:0] char_x;
    logic [`FRAME_YW-1:0] char_y;
    logic [`SCR_XW-1:0]   scr_x;
    logic [`SCR_YW-1:0]   scr_y;
    logic [`FRAME_XW-1:0] pos_x;
    logic [`FRAME_YW-1:0] pos_y;
    logic                 pos_last;

    pixel_t               char_pxl;
    char_attr_t           char_attr;
    logic                 char_valid;
    pixel_t               scr_pxl;
    scr_attr_t            scr_attr;
    logic                 scr_valid;

    logic [`FRAME_XW-1:0] d1_x;
    logic [`FRAME_XW-1:0] d2_x;
    logic [`FRAME_YW-1:0] d1_y;
    logic [`FRAME_YW-1:0] d2_y;
    logic                 d1_last;
    logic                 d2_last;

    raster_scan u_raster (
        .clk       ( clk        ),
        .reset     ( reset      ),
        .render_en ( render_en  ),
        .advance   ( advance    ),
        .scr_vpos  ( scr_vpos   ),
        .scr_hpos  ( scr_hpos   ),
        .pos_done  ( pos_done   ),
        .busy      ( busy       ),
        .pos_valid ( pos_valid  ),
        .char_x    ( char_x     ),
        .char_y    ( char_y     ),
        .scr_x     ( scr_x      ),
        .scr_y     ( scr_y      ),
        .pos_x     ( pos_x      ),
        .pos_y     ( pos_y      ),
        .pos_last  ( pos_last   )
    );

    tile_layer #(
        .attr_t ( char_attr_t  ),
        .MAP_W  ( `CHAR_MAP_W  ),
        .MAP_H  ( `CHAR_MAP_H  )
    ) u_char (
        .clk       ( clk        ),
        .reset     ( reset      ),
        .advance   ( advance    ),
        .cpu_we    ( cpu_we     ),
        .cpu_sel   ( char_cs    ),
        .cpu_addr  ( cpu_addr   ),
        .cpu_din   ( cpu_din    ),
        .tx        ( char_x     ),
        .ty        ( char_y     ),
        .in_valid  ( pos_valid  ),
        .pxl       ( char_pxl   ),
        .attr      ( char_attr  ),
        .out_valid ( char_valid )
    );

    tile_layer #(
        .attr_t ( scr_attr_t   ),
        .MAP_W  ( `SCR_MAP_W   ),
        .MAP_H  ( `SCR_MAP_H   )
    ) u_scroll (
        .clk       ( clk        ),
        .reset     ( reset      ),
        .advance   ( advance    ),
        .cpu_we    ( cpu_we     ),
        .cpu_sel   ( scr_cs     ),
        .cpu_addr  ( cpu_addr   ),
        .cpu_din   ( cpu_din    ),
        .tx        ( scr_x      ),
        .ty        ( scr_y      ),
        .in_valid  ( pos_valid  ),
        .pxl       ( scr_pxl    ),
        .attr      ( scr_attr   ),
        .out_valid ( scr_valid  )
    );

    // Coordinates follow the two fetch stages of the layers
    always_ff @(posedge clk) begin
        if (advance) begin
            d1_x    <= pos_x;
            d1_y    <= pos_y;
            d1_last <= pos_last;
            d2_x    <= d1_x;
            d2_y    <= d1_y;
            d2_last <= d1_last;
        end
    end

    color_mixer u_mixer (
        .clk       ( clk                     ),
        .reset     ( reset                   ),
        .in_valid  ( char_valid && scr_valid ),
        .char_pxl  ( char_pxl                ),
        .char_attr ( char_attr               ),
        .scr_pxl   ( scr_pxl                 ),
        .scr_attr  ( scr_attr                ),
        .in_x      ( d2_x                    ),
        .in_y      ( d2_y                    ),
        .in_last   ( d2_last                 ),
        .cpu_we    ( cpu_we                  ),
        .pal_cs    ( pal_cs                  ),
        .cpu_addr  ( cpu_addr[7:0]           ),
        .cpu_din   ( cpu_din                 ),
        .out_ready ( out_ready               ),
        .advance   ( advance                 ),
        .pos_done  ( pos_done                ),
        .out_valid ( out_valid               ),
        .out_x     ( out_x                   ),
        .out_y     ( out_y                   ),
        .out_last  ( out_last                ),
        .red       ( red                     ),
        .green     ( green                   ),
        .blue      ( blue                    )
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 8
)(
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== tb/video_checker.sv ====
`timescale 1ns/1ns
`include "video_settings.svh"
`default_nettype none

module video_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  logic [`FRAME_XW-1:0]  out_x,
    input  logic [`FRAME_YW-1:0]  out_y,
    input  logic                  out_last,
    input  logic [3:0]            red,
    input  logic [3:0]            green,
    input  logic [3:0]            blue
);

    // Entry layout kind[26:24] x[23:18] y[17:13] last[12] r[11:8] g[7:4] b[3:0]
    logic [26:0] exp_q [$];
    logic [26:0] exp_pix;
    int          errors = 0;
    int          case_seen [5] = '{default: 0};

    task expect_pixel(input logic [26:0] pix);
        exp_q.push_back(pix);
    endtask

    task value_error(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, want);
        errors++;
    endtask

    task fault(input string msg);
        $display("Error: %s", msg);
        errors++;
    endtask

    // Anything still queued after a frame never came out
    task flush_missing();
        if (exp_q.size() != 0)
            fault($sformatf("%0d expected pixels never arrived", exp_q.size()));
        exp_q.delete();
    endtask

    task clear_cases();
        for (int i = 0; i < 5; i++)
            case_seen[i] = 0;
    endtask

    task check_cases();
        for (int i = 0; i < 5; i++) begin
            if (case_seen[i] == 0)
                fault($sformatf("mixing case %0d was never exercised", i));
        end
    endtask

    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                fault($sformatf("extra pixel at (%0d,%0d) with none expected", out_x, out_y));
            end else begin
                exp_pix = exp_q.pop_front();
                case_seen[exp_pix[26:24]]++;
                if (out_x !== exp_pix[23:18])
                    value_error("out_x", out_x, exp_pix[23:18]);
                if (out_y !== exp_pix[17:13])
                    value_error("out_y", out_y, exp_pix[17:13]);
                if (out_last !== exp_pix[12])
                    value_error("out_last", out_last, exp_pix[12]);
                if (red !== exp_pix[11:8])
                    value_error("red", red, exp_pix[11:8]);
                if (green !== exp_pix[7:4])
                    value_error("green", green, exp_pix[7:4]);
                if (blue !== exp_pix[3:0])
                    value_error("blue", blue, exp_pix[3:0]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tile_video_tb.sv ====
`timescale 1ns/1ns
`include "video_settings.svh"
`default_nettype none

module tile_video_tb;

    localparam longint WATCHDOG_NS = 64'd6 * 2048 * 4 * 8;

    logic                 clk;
    logic                 reset;
    logic                 cpu_we;
    logic [9:0]           cpu_addr;
    logic [7:0]           cpu_din;
    logic                 char_cs;
    logic                 scr_cs;
    logic                 pal_cs;
    logic                 render_en;
    logic [`SCR_XW-1:0]   scr_hpos;
    logic [`SCR_YW-1:0]   scr_vpos;
    logic                 busy;
    logic                 out_valid;
    logic                 out_ready;
    logic [`FRAME_XW-1:0] out_x;
    logic [`FRAME_YW-1:0] out_y;
    logic                 out_last;
    logic [3:0]           red;
    logic [3:0]           green;
    logic [3:0]           blue;

    logic [31:0] lfsr = 32'd91299;
    logic        random_ready = 1'b0;
    int          err_mark = 0;
    int          passed = 0;

    // Mirror of everything the CPU wrote
    logic [3:0] m_char_code [32];
    logic [7:0] m_char_attr [32];
    logic [7:0] m_char_pat  [512];
    logic [3:0] m_scr_code  [128];
    logic [7:0] m_scr_attr  [128];
    logic [7:0] m_scr_pat   [512];
    logic [7:0] m_pal_rg    [128];
    logic [3:0] m_pal_b     [128];

    tb_clock #(.PERIOD_NS(8)) u_clock (.clk(clk));

    tile_video dut (
        .clk(clk), .reset(reset), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_din(cpu_din),
        .char_cs(char_cs), .scr_cs(scr_cs), .pal_cs(pal_cs), .render_en(render_en),
        .scr_hpos(scr_hpos), .scr_vpos(scr_vpos), .busy(busy), .out_valid(out_valid),
        .out_ready(out_ready), .out_x(out_x), .out_y(out_y), .out_last(out_last),
        .red(red), .green(green), .blue(blue)
    );

    video_checker u_check (
        .clk(clk), .reset(reset), .out_valid(out_valid), .out_ready(out_ready),
        .out_x(out_x), .out_y(out_y), .out_last(out_last),
        .red(red), .green(green), .blue(blue)
    );

    // Taps 32, 22, 2 and 1 with one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Half of the nibbles come out transparent
    function automatic logic [7:0] sparse_byte();
        logic [3:0] lo;
        logic [3:0] hi;
        lo = rand_bits(1) ? 4'h0 : 4'(rand_bits(4));
        hi = rand_bits(1) ? 4'h0 : 4'(rand_bits(4));
        return {hi, lo};
    endfunction

    function automatic logic [26:0] model_pixel(input int x, input int y, input int hoff,
                                                input int voff);
        int         ci;
        int         si;
        int         col;
        int         sx;
        int         sy;
        logic [7:0] pb;
        logic [3:0] c;
        logic [3:0] s;
        logic       sel_char;
        logic [2:0] kind;
        logic [6:0] pi;
        ci  = (y / 8) * 8 + x / 8;
        col = m_char_attr[ci][5] ? 7 - x % 8 : x % 8;
        pb  = m_char_pat[m_char_code[ci] * 32 + (y % 8) * 4 + col / 2];
        c   = (col % 2) ? pb[7:4] : pb[3:0];
        sx  = (x + hoff) % 128;
        sy  = (y + voff) % 64;
        si  = (sy / 8) * 16 + sx / 8;
        col = m_scr_attr[si][5] ? 7 - sx % 8 : sx % 8;
        pb  = m_scr_pat[m_scr_code[si] * 32 + (sy % 8) * 4 + col / 2];
        s   = (col % 2) ? pb[7:4] : pb[3:0];
        // Both opaque splits on prio, otherwise the opaque layer or scroll wins
        if (c != 0 && s != 0)
            kind = m_scr_attr[si][4] ? 3'd0 : 3'd1;
        else if (c != 0)
            kind = 3'd2;
        else if (s != 0)
            kind = 3'd3;
        else
            kind = 3'd4;
        sel_char = (kind == 3'd1 || kind == 3'd2);
        pi = sel_char ? {1'b1, m_char_attr[ci][7:6], c} : {1'b0, m_scr_attr[si][7:6], s};
        return {kind, 6'(x), 5'(y), (x == 63 && y == 31), m_pal_rg[pi], m_pal_b[pi]};
    endfunction

    // Called on a falling edge and returns on the next one
    task cpu_write(input int sel, input logic [9:0] addr, input logic [7:0] din);
        cpu_we   = 1'b1;
        cpu_addr = addr;
        cpu_din  = din;
        char_cs  = (sel == 0);
        scr_cs   = (sel == 1);
        pal_cs   = (sel == 2);
        case (sel)
            0: if (addr[9]) m_char_pat[addr[8:0]] = din;
               else if (addr[0]) m_char_attr[addr[5:1]] = din;
               else m_char_code[addr[5:1]] = din[3:0];
            1: if (addr[9]) m_scr_pat[addr[8:0]] = din;
               else if (addr[0]) m_scr_attr[addr[7:1]] = din;
               else m_scr_code[addr[7:1]] = din[3:0];
            default: if (addr[7]) m_pal_b[addr[6:0]] = din[3:0];
                     else m_pal_rg[addr[6:0]] = din;
        endcase
        @(negedge clk);
        cpu_we  = 1'b0;
        char_cs = 1'b0;
        scr_cs  = 1'b0;
        pal_cs  = 1'b0;
    endtask

    task load_maps();
        for (int n = 0; n < 32; n++) begin
            cpu_write(0, 10'(2 * n), 8'(rand_bits(8)));
            cpu_write(0, 10'(2 * n + 1), 8'(rand_bits(8)));
        end
        for (int n = 0; n < 128; n++) begin
            cpu_write(1, 10'(2 * n), 8'(rand_bits(8)));
            cpu_write(1, 10'(2 * n + 1), 8'(rand_bits(8)));
        end
    endtask

    task load_patterns(input bit sparse);
        for (int i = 0; i < 512; i++) begin
            cpu_write(0, 10'(512 + i), sparse ? sparse_byte() : 8'(rand_bits(8)));
            cpu_write(1, 10'(512 + i), sparse ? sparse_byte() : 8'(rand_bits(8)));
        end
    endtask

    task load_palette();
        for (int i = 0; i < 128; i++) begin
            cpu_write(2, 10'(i), 8'(rand_bits(8)));
            cpu_write(2, 10'(128 + i), 8'(rand_bits(8)));
        end
    endtask

    task run_frame(input int hoff, input int voff);
        for (int y = 0; y < `FRAME_H; y++) begin
            for (int x = 0; x < `FRAME_W; x++)
                u_check.expect_pixel(model_pixel(x, y, hoff, voff));
        end
        scr_hpos  = 7'(hoff);
        scr_vpos  = 6'(voff);
        render_en = 1'b1;
        @(negedge clk);
        render_en = 1'b0;
        if (busy !== 1'b1)
            u_check.fault("frame did not start when render_en was raised");
        while (busy === 1'b1)
            @(negedge clk);
        u_check.flush_missing();
    endtask

    task finish_test(input int num, input string name);
        if (u_check.errors == err_mark) begin
            passed++;
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: %0d errors", num, name, u_check.errors - err_mark);
        end
        err_mark = u_check.errors;
    endtask

    // Back-pressure source for test 5
    always @(negedge clk) begin
        if (random_ready)
            out_ready = rand_bits(1);
        else
            out_ready = 1'b1;
    end

    initial begin
        reset     = 1'b1;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_din   = '0;
        char_cs   = 1'b0;
        scr_cs    = 1'b0;
        pal_cs    = 1'b0;
        render_en = 1'b0;
        scr_hpos  = '0;
        scr_vpos  = '0;
        out_ready = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        if (busy !== 1'b0)
            u_check.value_error("busy", busy, 0);
        repeat (40) begin
            @(negedge clk);
            if (out_valid !== 1'b0)
                u_check.value_error("out_valid", out_valid, 0);
        end
        finish_test(1, "idle after reset");

        load_maps();
        load_patterns(1'b0);
        load_palette();
        run_frame(0, 0);
        finish_test(2, "random frame, no scroll");

        // Offsets large enough to wrap both axes
        run_frame(64 | rand_bits(6) | 1, 32 | rand_bits(5) | 1);
        finish_test(3, "scrolled frame with wrap");

        load_maps();
        load_patterns(1'b1);
        u_check.clear_cases();
        run_frame(rand_bits(7), rand_bits(6));
        u_check.check_cases();
        finish_test(4, "priority and transparency");

        load_maps();
        random_ready = 1'b1;
        run_frame(rand_bits(7), rand_bits(6));
        random_ready = 1'b0;
        finish_test(5, "random back-pressure");

        load_palette();
        run_frame(rand_bits(7), rand_bits(6));
        finish_test(6, "palette rewrite");

        $display("Tests passed: %0d of 6, errors: %0d", passed, u_check.errors);
        if (u_check.errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not complete within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tile_video.f ====
+incdir+hw
hw/video_pkg.sv
hw/raster_scan.sv
hw/tile_layer.sv
hw/color_mixer.sv
hw/tile_video.sv
tb/tb_clock.sv
tb/video_checker.sv
tb/tile_video_tb.sv

// ==== Makefile ====
TB_TOP  = tile_video_tb
RTL_TOP = tile_video

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module $(RTL_TOP) -f tile_video.f

obj_dir/V$(TB_TOP): tile_video.f hw/*.sv hw/*.svh tb/*.sv
	verilator --binary --timing --assert --top-module $(TB_TOP) -f tile_video.f

sim: obj_dir/V$(TB_TOP)
	./obj_dir/V$(TB_TOP) > sim.log 2>&1; status=$$?; cat sim.log; test $$status -eq 0
	@if grep -qF '*** TEST FAILED ***' sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
